/* filelist.f */
logic/flit_pkg.sv
logic/port_pkg.sv
logic/inject_eject.sv
logic/route_compute.sv
logic/age_sorter.sv
logic/switch_alloc.sv
logic/router_top.sv
verif/router_tb.sv

/* Makefile */
TOP  := router_tb
SIM  := obj_dir/V$(TOP)
SRCS := $(shell cat filelist.f)

.PHONY: all run clean

all: run

$(SIM): filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf obj_dir

/* verif/router_tb.sv */
`timescale 1ns/100ps

module router_tb
    import flit_pkg::*;
    import port_pkg::*;
;

    localparam coord_t my_x = 3'd3;
    localparam coord_t my_y = 3'd4;

    localparam int reset_cycles    = 8;
    localparam int directed_cycles = 64;
    localparam int random_cycles   = 400;
    localparam int margin_cycles   = 100;
    localparam int watchdog_cycles =
        reset_cycles + directed_cycles + random_cycles + margin_cycles;

    typedef logic [num_lanes*$bits(flit_t)-1:0] wide_t;

    logic                  clk = 1'b0;
    logic                  n_rst = 1'b0;
    flit_t [num_lanes-1:0] net_in = '0;
    flit_t                 local_in = '0;
    flit_t [num_lanes-1:0] net_out;
    flit_t                 local_out;

    // expected outputs, shifted along at every falling edge
    flit_t [num_lanes-1:0] exp_net = '0;
    flit_t [num_lanes-1:0] stage_net = '0;
    flit_t [num_lanes-1:0] new_net = '0;
    flit_t                 exp_local = '0;
    flit_t                 new_local = '0;
    logic                  chk_en = 1'b0;

    integer seed = 32'h996f;

    router_top #(
        .router_x (my_x),
        .router_y (my_y)
    ) dut0 (
        .clk       (clk),
        .n_rst     (n_rst),
        .net_in    (net_in),
        .local_in  (local_in),
        .net_out   (net_out),
        .local_out (local_out)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic flit_t make_flit(input coord_t x, input coord_t y,
                                        input age_t age, input payload_t pl);
        flit_t f;
        f.valid   = 1'b1;
        f.dst_x   = x;
        f.dst_y   = y;
        f.age     = age;
        f.payload = pl;
        return f;
    endfunction

    // true when a goes ahead of b in the age order
    function automatic logic ranks_before(input flit_t a, input flit_t b);
        return (a.valid && !b.valid) || (a.valid && b.valid && (a.age > b.age));
    endfunction

    task automatic route_model(input flit_t [num_lanes-1:0] net, input flit_t loc,
                               output flit_t ej, output flit_t [num_lanes-1:0] outp);
        flit_t     [num_lanes-1:0] lane;
        port_vec_t [num_lanes-1:0] pv;
        logic      [num_lanes-1:0] taken;
        port_vec_t                 free_ports;
        logic                      placed;
        int                        best;
        int                        pick;
        int                        port;

        // oldest flit for this node leaves on the local port
        best = -1;
        for (int i = 0; i < num_lanes; i++) begin
            if (net[i].valid && net[i].dst_x == my_x && net[i].dst_y == my_y) begin
                if (best < 0 || net[i].age > net[best].age) begin
                    best = i;
                end
            end
        end
        lane = net;
        ej   = '0;
        if (best >= 0) begin
            ej         = net[best];
            lane[best] = '0;
        end

        placed = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            if (loc.valid && !placed && !lane[i].valid) begin
                lane[i] = loc;
                placed  = 1'b1;
            end
        end

        for (int i = 0; i < num_lanes; i++) begin
            pv[i] = '0;
            if (lane[i].valid) begin
                pv[i][dir_north] = lane[i].dst_y > my_y;
                pv[i][dir_south] = lane[i].dst_y < my_y;
                pv[i][dir_east]  = lane[i].dst_x > my_x;
                pv[i][dir_west]  = lane[i].dst_x < my_x;
            end
        end

        // pick the best remaining lane, then give it a port
        taken      = '0;
        free_ports = '1;
        outp       = '0;
        for (int r = 0; r < num_lanes; r++) begin
            pick = -1;
            for (int i = 0; i < num_lanes; i++) begin
                if (!taken[i] && (pick < 0 || ranks_before(lane[i], lane[pick]))) begin
                    pick = i;
                end
            end
            taken[pick] = 1'b1;
            if (lane[pick].valid) begin
                port = -1;
                for (int p = 0; p < num_dirs; p++) begin
                    if (port < 0 && pv[pick][p] && free_ports[p]) begin
                        port = p;
                    end
                end
                // deflection
                for (int p = 0; p < num_dirs; p++) begin
                    if (port < 0 && free_ports[p]) begin
                        port = p;
                    end
                end
                free_ports[port] = 1'b0;
                outp[port]       = lane[pick];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    // one input set per falling edge
    task automatic apply(input flit_t [num_lanes-1:0] net, input flit_t loc,
                         input logic rst_val);
        @(negedge clk);
        exp_net   = stage_net;
        exp_local = new_local;
        // a reset edge clears the stage-1 register
        stage_net = rst_val ? new_net : '0;
        n_rst     = rst_val;
        net_in    = net;
        local_in  = loc;
        if (rst_val) begin
            route_model(net, loc, new_local, new_net);
        end else begin
            new_local = '0;
            new_net   = '0;
        end
        chk_en = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) apply('0, '0, 1'b1);
    endtask

    // busy inputs while n_rst is low, outputs must still stay zero
    task automatic hold_reset(input int n);
        flit_t [num_lanes-1:0] net;
        flit_t                 loc;

        net[0] = make_flit(my_x, my_y, 8'd50, 32'h0bad_0000);
        net[1] = make_flit(3'd6, 3'd6, 8'd51, 32'h0bad_0001);
        net[2] = make_flit(3'd0, 3'd2, 8'd52, 32'h0bad_0002);
        net[3] = make_flit(3'd3, 3'd7, 8'd53, 32'h0bad_0003);
        loc    = make_flit(3'd1, 3'd1, 8'd54, 32'h0bad_0004);
        repeat (n) apply(net, loc, 1'b0);
    endtask

    task automatic single_flits();
        coord_t tx [num_lanes];
        coord_t ty [num_lanes];
        flit_t [num_lanes-1:0] net;

        // east, north, south and west, one per input port
        tx = '{3'd5, 3'd3, 3'd0, 3'd1};
        ty = '{3'd4, 3'd7, 3'd1, 3'd4};
        for (int d = 0; d < num_lanes; d++) begin
            net    = '0;
            net[d] = make_flit(tx[d], ty[d], 8'd7, 32'h1000_0000 + d);
            apply(net, '0, 1'b1);
            idle(3);
        end
    endtask

    task automatic eject_cases();
        flit_t [num_lanes-1:0] net;

        net    = '0;
        net[1] = make_flit(my_x, my_y, 8'd3, 32'hcafe_0001);
        apply(net, '0, 1'b1);
        idle(3);

        // the younger one cannot leave and is deflected
        net    = '0;
        net[0] = make_flit(my_x, my_y, 8'd10, 32'hcafe_0010);
        net[2] = make_flit(my_x, my_y, 8'd20, 32'hcafe_0020);
        apply(net, '0, 1'b1);
        idle(3);
    endtask

    task automatic east_contention();
        flit_t [num_lanes-1:0] net;

        net[0] = make_flit(3'd6, my_y, 8'd5, 32'hbeef_0005);
        net[1] = make_flit(3'd6, my_y, 8'd40, 32'hbeef_0040);
        net[2] = make_flit(3'd6, my_y, 8'd20, 32'hbeef_0020);
        net[3] = make_flit(3'd6, my_y, 8'd30, 32'hbeef_0030);
        apply(net, '0, 1'b1);
        idle(3);
    endtask

    task automatic local_cases();
        flit_t [num_lanes-1:0] net;
        flit_t                 loc;

        net    = '0;
        net[0] = make_flit(3'd0, my_y, 8'd9, 32'h5a5a_0000);
        loc    = make_flit(3'd3, 3'd0, 8'd1, 32'h5a5a_0001);
        apply(net, loc, 1'b1);
        idle(3);

        // all lanes busy, nothing ejected, the local flit is lost
        net[1] = make_flit(3'd7, 3'd7, 8'd11, 32'h5a5a_0011);
        net[2] = make_flit(3'd2, 3'd2, 8'd12, 32'h5a5a_0012);
        net[3] = make_flit(3'd5, 3'd1, 8'd13, 32'h5a5a_0013);
        loc    = make_flit(3'd0, 3'd0, 8'd99, 32'hdead_dead);
        apply(net, loc, 1'b1);
        idle(3);
    endtask

    // reset hits while both registers hold traffic
    task automatic reset_in_flight();
        flit_t [num_lanes-1:0] net;

        net    = '0;
        net[1] = make_flit(3'd6, 3'd1, 8'd8, 32'h7e57_0001);
        net[3] = make_flit(my_x, my_y, 8'd9, 32'h7e57_0003);
        apply(net, '0, 1'b1);
        apply(net, '0, 1'b1);
        hold_reset(2);
        idle(3);
    endtask

    function automatic flit_t random_flit(input logic [31:0] r, input logic [31:0] pl);
        flit_t f;
        f = '0;
        if (r[1:0] != 2'b00) begin
            f.valid = 1'b1;
            f.dst_x = r[4:2];
            f.dst_y = r[7:5];
            // bias toward this node so that ejection happens often
            if (r[8] && r[9]) begin
                f.dst_x = my_x;
                f.dst_y = my_y;
            end
            // small ages give plenty of ties
            f.age     = r[18] ? age_t'(r[11:10]) : r[17:10];
            f.payload = pl;
        end
        return f;
    endfunction

    task automatic random_traffic();
        flit_t [num_lanes-1:0] net;
        flit_t                 loc;
        logic [31:0]           r;
        logic [31:0]           pl;

        for (int n = 0; n < random_cycles; n++) begin
            for (int i = 0; i < num_lanes; i++) begin
                r      = $random(seed);
                pl     = $random(seed);
                net[i] = random_flit(r, pl);
            end
            r   = $random(seed);
            pl  = $random(seed);
            loc = random_flit(r, pl);
            apply(net, loc, 1'b1);
        end
        idle(3);
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string port, input wide_t got, input wide_t exp);
        $display("[ERROR] time %0t: %s mismatch, got %h expected %h", $time, port, got, exp);
        $display("TEST FAILED");
        $fatal(1, "output check failed");
    endtask

    // sampled values are the ones held since the last falling edge
    net_out_chk: assert property (@(posedge clk) !chk_en || (net_out == exp_net))
        else report_mismatch("net_out", wide_t'($sampled(net_out)),
                             wide_t'($sampled(exp_net)));

    local_out_chk: assert property (@(posedge clk) !chk_en || (local_out == exp_local))
        else report_mismatch("local_out", wide_t'($sampled(local_out)),
                             wide_t'($sampled(exp_local)));

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        hold_reset(reset_cycles);
        idle(2);
        single_flits();
        eject_cases();
        east_contention();
        local_cases();
        reset_in_flight();
        random_traffic();
        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

/* logic/router_top.sv */
`timescale 1ns/100ps

module router_top
    import flit_pkg::*;
    import port_pkg::*;
#(
    parameter coord_t router_x = '0,
    parameter coord_t router_y = '0
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  flit_t [num_lanes-1:0] net_in,
    input  flit_t                 local_in,
    output flit_t [num_lanes-1:0] net_out,
    output flit_t                 local_out
);

    flit_t     [num_lanes-1:0] lanes;
    port_vec_t [num_lanes-1:0] ppv;
    flit_t     [num_lanes-1:0] st1_flits;
    port_vec_t [num_lanes-1:0] st1_ppv;

    // stage 0, input register then eject and inject
    inject_eject #(
        .router_x (router_x),
        .router_y (router_y)
    ) u_inject_eject (
        .clk       (clk),
        .n_rst     (n_rst),
        .net_in    (net_in),
        .local_in  (local_in),
        .lanes     (lanes),
        .local_out (local_out)
    );

    route_compute #(
        .router_x (router_x),
        .router_y (router_y)
    ) u_route_compute (
        .lanes (lanes),
        .ppv   (ppv)
    );

    // holds the stage-1 register
    age_sorter u_age_sorter (
        .clk       (clk),
        .n_rst     (n_rst),
        .lanes     (lanes),
        .ppv       (ppv),
        .st1_flits (st1_flits),
        .st1_ppv   (st1_ppv)
    );

    // stage 1, allocation and crossbar
    switch_alloc u_switch_alloc (
        .st1_flits (st1_flits),
        .st1_ppv   (st1_ppv),
        .net_out   (net_out)
    );

endmodule

/* logic/switch_alloc.sv */
`timescale 1ns/100ps

module switch_alloc
    import flit_pkg::*;
    import port_pkg::*;
(
    input  flit_t     [num_lanes-1:0] st1_flits,
    input  port_vec_t [num_lanes-1:0] st1_ppv,
    output flit_t     [num_lanes-1:0] net_out
);

    port_vec_t                 free_ports;
    port_vec_t                 want;
    port_vec_t [num_lanes-1:0] grant;

    // lowest set bit as a one-hot vector
    function automatic port_vec_t lowest_one(input port_vec_t v);
        return v & (~v + port_vec_t'(1));
    endfunction

    ////////////////////////////////////////////////////////////
    // allocation in rank order
    ////////////////////////////////////////////////////////////

    // rank 0 is the oldest flit and picks first
    // lanes never outnumber ports, so a free port is always left
    always_comb begin
        free_ports = '1;
        want       = '0;
        grant      = '0;
        for (int r = 0; r < num_lanes; r++) begin
            if (st1_flits[r].valid) begin
                want = st1_ppv[r] & free_ports;
                // no productive port left, deflect
                if (want == '0) begin
                    want = free_ports;
                end
                grant[r]   = lowest_one(want);
                free_ports = free_ports & ~grant[r];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // crossbar
    ////////////////////////////////////////////////////////////

    // grants are one-hot and disjoint, idle ports stay zero
    always_comb begin
        net_out = '0;
        for (int p = 0; p < num_dirs; p++) begin
            for (int r = 0; r < num_lanes; r++) begin
                if (grant[r][p]) begin
                    net_out[p] = st1_flits[r];
                end
            end
        end
    end

endmodule

/* logic/age_sorter.sv */
`timescale 1ns/100ps

module age_sorter
    import flit_pkg::*;
    import port_pkg::*;
(
    input  logic                         clk,
    input  logic                         n_rst,
    input  flit_t     [num_lanes-1:0]    lanes,
    input  port_vec_t [num_lanes-1:0]    ppv,
    output flit_t     [num_lanes-1:0]    st1_flits,
    output port_vec_t [num_lanes-1:0]    st1_ppv
);

    // flit plus its routing vector, lane kept for tie breaking
    typedef struct packed {
        flit_t     flit;
        port_vec_t ppv;
        rank_t     lane;
    } sort_ent_t;

    // element 0 goes to the lower (older) position
    typedef sort_ent_t [1:0] ent_pair_t;

    localparam int key_w = 1 + $bits(age_t) + $bits(rank_t);

    sort_ent_t [num_lanes-1:0] s_in;
    sort_ent_t [num_lanes-1:0] s_a;
    sort_ent_t [num_lanes-1:0] s_b;
    sort_ent_t [num_lanes-1:0] s_c;

    // valid first, then older, then lower lane
    // inverted lane index makes every key distinct, so the
    // network behaves like a stable sort
    function automatic logic [key_w-1:0] sort_key(input sort_ent_t e);
        return {e.flit.valid, e.flit.age, ~e.lane};
    endfunction

    // compare and swap, larger key stays in front
    function automatic ent_pair_t cas(input sort_ent_t a, input sort_ent_t b);
        ent_pair_t res;
        if (sort_key(b) > sort_key(a)) begin
            res[0] = b;
            res[1] = a;
        end else begin
            res[0] = a;
            res[1] = b;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            s_in[i].flit = lanes[i];
            s_in[i].ppv  = ppv[i];
            s_in[i].lane = rank_t'(i);
        end
    end

    ////////////////////////////////////////////////////////////
    // five-cell sorting network, three levels
    ////////////////////////////////////////////////////////////

    always_comb begin
        {s_a[1], s_a[0]} = cas(s_in[0], s_in[1]);
        {s_a[3], s_a[2]} = cas(s_in[2], s_in[3]);

        {s_b[2], s_b[0]} = cas(s_a[0], s_a[2]);
        {s_b[3], s_b[1]} = cas(s_a[1], s_a[3]);

        s_c[0] = s_b[0];
        {s_c[2], s_c[1]} = cas(s_b[1], s_b[2]);
        s_c[3] = s_b[3];
    end

    ////////////////////////////////////////////////////////////
    // stage-1 register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            st1_flits <= '0;
            st1_ppv   <= '0;
        end else begin
            for (int r = 0; r < num_lanes; r++) begin
                st1_flits[r] <= s_c[r].flit;
                st1_ppv[r]   <= s_c[r].ppv;
            end
        end
    end

endmodule

/* logic/route_compute.sv */
`timescale 1ns/100ps

module route_compute
    import flit_pkg::*;
    import port_pkg::*;
#(
    parameter coord_t router_x = '0,
    parameter coord_t router_y = '0
) (
    input  flit_t     [num_lanes-1:0] lanes,
    output port_vec_t [num_lanes-1:0] ppv
);

    // minimal routing, every direction that closes the distance
    // a flit sitting on its own node gets no bits
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            ppv[i] = '0;
            if (lanes[i].valid) begin
                // x dimension
                ppv[i][dir_east]  = lanes[i].dst_x > router_x;
                ppv[i][dir_west]  = lanes[i].dst_x < router_x;
                // y dimension
                ppv[i][dir_north] = lanes[i].dst_y > router_y;
                ppv[i][dir_south] = lanes[i].dst_y < router_y;
            end
        end
    end

endmodule

/* logic/inject_eject.sv */
`timescale 1ns/100ps

module inject_eject
    import flit_pkg::*;
#(
    parameter coord_t router_x = '0,
    parameter coord_t router_y = '0
) (
    input  logic                    clk,
    input  logic                    n_rst,
    input  flit_t [num_lanes-1:0]   net_in,
    input  flit_t                   local_in,
    output flit_t [num_lanes-1:0]   lanes,
    output flit_t                   local_out
);

    flit_t [num_lanes-1:0] net_q;
    flit_t                 local_q;

    logic [num_lanes-1:0]  here;
    logic [num_lanes-1:0]  eject_sel;
    logic                  eject_found;
    age_t                  eject_age;

    flit_t [num_lanes-1:0] kept;
    logic                  inj_done;

    ////////////////////////////////////////////////////////////
    // input register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            net_q   <= '0;
            local_q <= '0;
        end else begin
            net_q   <= net_in;
            local_q <= local_in;
        end
    end

    ////////////////////////////////////////////////////////////
    // ejection
    ////////////////////////////////////////////////////////////

    // valid flits that have arrived at this node
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            here[i] = net_q[i].valid &&
                      (net_q[i].dst_x == router_x) &&
                      (net_q[i].dst_y == router_y);
        end
    end

    // oldest one wins, strict compare keeps the lower port on a tie
    always_comb begin
        eject_found = 1'b0;
        eject_age   = '0;
        eject_sel   = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (here[i] && (!eject_found || (net_q[i].age > eject_age))) begin
                eject_found  = 1'b1;
                eject_age    = net_q[i].age;
                eject_sel    = '0;
                eject_sel[i] = 1'b1;
            end
        end
    end

    // at most one bit of eject_sel is set
    always_comb begin
        local_out = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (eject_sel[i]) begin
                local_out = net_q[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // injection
    ////////////////////////////////////////////////////////////

    // ejected lane becomes an empty slot
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            kept[i] = eject_sel[i] ? '0 : net_q[i];
        end
    end

    // local flit drops into the lowest empty lane, lost if none
    always_comb begin
        lanes    = kept;
        inj_done = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            if (local_q.valid && !inj_done && !kept[i].valid) begin
                lanes[i] = local_q;
                inj_done = 1'b1;
            end
        end
    end

endmodule

/* logic/port_pkg.sv */
package port_pkg;

    // one bit per output direction
    localparam int num_dirs = 4;

    // port index, also the bit position in a port vector
    typedef logic [1:0] dir_t;

    // north and east point toward larger y and x
    localparam dir_t dir_north = 2'd0;
    localparam dir_t dir_east  = 2'd1;
    localparam dir_t dir_south = 2'd2;
    localparam dir_t dir_west  = 2'd3;

    typedef logic [num_dirs-1:0] port_vec_t;

    // input lane that holds a given rank
    typedef logic [1:0] rank_t;

endpackage

/* logic/flit_pkg.sv */
package flit_pkg;

    ////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////

    // 3 bits per coordinate, up to an 8 by 8 mesh
    localparam int coord_w   = 3;
    localparam int age_w     = 8;
    localparam int payload_w = 32;

    // four network ports, one lane each
    localparam int num_lanes = 4;

    ////////////////////////////////////////////////////////////
    // flit format
    ////////////////////////////////////////////////////////////

    typedef logic [coord_w-1:0]   coord_t;

    // larger value means older
    typedef logic [age_w-1:0]     age_t;

    typedef logic [payload_w-1:0] payload_t;

    // 47 bits, an empty slot is all zero
    typedef struct packed {
        logic     valid;
        coord_t   dst_x;
        coord_t   dst_y;
        age_t     age;
        payload_t payload;
    } flit_t;

endpackage
